// File: src/axi_mem_slave_pkg.sv
`default_nettype none

package axi_mem_slave_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 3;

    // One response queue per read ID
    localparam int N_IDS = 1 << ID_WIDTH;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ID_WIDTH-1:0]   id_t;

    // ------------------------------------------------------------
    // Ready generator
    // ------------------------------------------------------------
    typedef logic [15:0] lfsr_t;

    // Non-zero start value, the all-zero state would lock up
    localparam lfsr_t LFSR_SEED = 16'hACE1;

endpackage

`default_nettype wire

// File: src/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter int WIDTH      = 32,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             push,
    input  wire logic [WIDTH-1:0] push_data,
    input  wire logic             pop,
    output logic      [WIDTH-1:0] head,
    output logic                  empty,
    output logic                  full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];

    // Extra top bit tells a full FIFO from an empty one
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign head = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage itself
    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_data;
        end
    end

endmodule

`default_nettype wire

// File: src/ready_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

module ready_lfsr (
    input  wire logic                clk,
    input  wire logic                rst,
    output logic                     aw_allow,
    output logic                     w_allow,
    output logic                     ar_allow,
    output axi_mem_slave_pkg::id_t   start_id
);

    axi_mem_slave_pkg::lfsr_t state;

    // Fibonacci LFSR, taps 15 13 12 10
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= axi_mem_slave_pkg::LFSR_SEED;
        end else begin
            state <= {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
        end
    end

    // OR of two bits gives about three cycles in four
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_allow <= 1'b0;
            aw_allow <= 1'b0;
            w_allow  <= 1'b0;
        end else begin
            ar_allow <= state[0] | state[1];
            aw_allow <= state[2] | state[3];
            w_allow  <= state[4] | state[5];
        end
    end

    assign start_id = state[axi_mem_slave_pkg::ID_WIDTH-1:0];

endmodule

`default_nettype wire

// File: src/write_join.sv
`timescale 1ns/1ns
`default_nettype none

module write_join #(
    parameter int MEM_DEPTH  = 256,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire axi_mem_slave_pkg::addr_t   awaddr,
    input  wire logic                       awvalid,
    input  wire axi_mem_slave_pkg::data_t   wdata,
    input  wire logic                       wvalid,
    input  wire logic                       aw_allow,
    input  wire logic                       w_allow,
    input  wire logic                       bready,
    output logic                            awready,
    output logic                            wready,
    output logic                            bvalid,
    output logic                            mem_we,
    output logic [$clog2(MEM_DEPTH)-1:0]    mem_waddr,
    output axi_mem_slave_pkg::data_t        mem_wdata
);

    axi_mem_slave_pkg::addr_t addr_head;
    logic addr_empty;
    logic addr_full;
    logic data_empty;
    logic data_full;
    logic resp_issue;
    // Responses owed to the master
    logic [15:0] owed;

    // ------------------------------------------------------------
    // Channel buffers
    // ------------------------------------------------------------
    assign awready = aw_allow && !addr_full;
    assign wready  = w_allow && !data_full;

    sync_fifo #(
        .WIDTH      (axi_mem_slave_pkg::ADDR_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) addr_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (awvalid && awready),
        .push_data (awaddr),
        .pop       (mem_we),
        .head      (addr_head),
        .empty     (addr_empty),
        .full      (addr_full)
    );

    sync_fifo #(
        .WIDTH      (axi_mem_slave_pkg::DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) data_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (wvalid && wready),
        .push_data (wdata),
        .pop       (mem_we),
        .head      (mem_wdata),
        .empty     (data_empty),
        .full      (data_full)
    );

    // ------------------------------------------------------------
    // Commit and write response
    // ------------------------------------------------------------
    assign mem_we    = !addr_empty && !data_empty;
    assign mem_waddr = addr_head[$clog2(MEM_DEPTH)-1:0];

    // New response goes out when the output slot is free
    assign resp_issue = (!bvalid || bready) && (owed != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            owed   <= '0;
            bvalid <= 1'b0;
        end else begin
            owed <= owed + {15'd0, mem_we} - {15'd0, resp_issue};
            if (!bvalid || bready) begin
                bvalid <= resp_issue;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/slave_memory.sv
`timescale 1ns/1ns
`default_nettype none

module slave_memory #(
    parameter int MEM_DEPTH = 256
) (
    input  wire logic                          clk,
    input  wire logic                          mem_we,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]  mem_waddr,
    input  wire axi_mem_slave_pkg::data_t      mem_wdata,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]  mem_raddr,
    output axi_mem_slave_pkg::data_t           mem_rdata
);

    axi_mem_slave_pkg::data_t mem [MEM_DEPTH];

    // Unwritten words read back as zero
    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // Old contents are seen during a same-edge write
    assign mem_rdata = mem[mem_raddr];

endmodule

`default_nettype wire

// File: src/read_queues.sv
`timescale 1ns/1ns
`default_nettype none

module read_queues #(
    parameter int MEM_DEPTH  = 256,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    input  wire axi_mem_slave_pkg::addr_t                      araddr,
    input  wire axi_mem_slave_pkg::id_t                        arid,
    input  wire logic                                          arvalid,
    input  wire logic                                          ar_allow,
    input  wire logic                                          pop,
    input  wire axi_mem_slave_pkg::id_t                        pop_id,
    input  wire axi_mem_slave_pkg::data_t                      mem_rdata,
    output logic                                               arready,
    output logic [$clog2(MEM_DEPTH)-1:0]                       mem_raddr,
    output logic [axi_mem_slave_pkg::N_IDS-1:0]                queue_valid,
    output axi_mem_slave_pkg::data_t [axi_mem_slave_pkg::N_IDS-1:0] queue_data
);

    logic [axi_mem_slave_pkg::N_IDS-1:0] queue_full;
    logic [axi_mem_slave_pkg::N_IDS-1:0] queue_empty;
    logic ar_fire;

    // ------------------------------------------------------------
    // Read acceptance
    // ------------------------------------------------------------
    // Hold off new reads while any queue has no room
    assign arready   = ar_allow && !(|queue_full);
    assign ar_fire   = arvalid && arready;
    assign mem_raddr = araddr[$clog2(MEM_DEPTH)-1:0];

    // ------------------------------------------------------------
    // Per-ID queues
    // ------------------------------------------------------------
    for (genvar i = 0; i < axi_mem_slave_pkg::N_IDS; i++) begin : g_queue
        sync_fifo #(
            .WIDTH      (axi_mem_slave_pkg::DATA_WIDTH),
            .FIFO_DEPTH (FIFO_DEPTH)
        ) id_fifo (
            .clk       (clk),
            .rst       (rst),
            .push      (ar_fire && (arid == axi_mem_slave_pkg::id_t'(i))),
            .push_data (mem_rdata),
            .pop       (pop && (pop_id == axi_mem_slave_pkg::id_t'(i))),
            .head      (queue_data[i]),
            .empty     (queue_empty[i]),
            .full      (queue_full[i])
        );

        assign queue_valid[i] = !queue_empty[i];
    end

endmodule

`default_nettype wire

// File: src/read_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module read_arbiter (
    input  wire logic                                               clk,
    input  wire logic                                               rst,
    input  wire logic [axi_mem_slave_pkg::N_IDS-1:0]                queue_valid,
    input  wire axi_mem_slave_pkg::data_t [axi_mem_slave_pkg::N_IDS-1:0] queue_data,
    input  wire axi_mem_slave_pkg::id_t                             start_id,
    input  wire logic                                               rready,
    output axi_mem_slave_pkg::data_t                                rdata,
    output axi_mem_slave_pkg::id_t                                  rid,
    output logic                                                    rvalid,
    output logic                                                    pop,
    output axi_mem_slave_pkg::id_t                                  pop_id
);

    logic found;
    logic out_free;
    axi_mem_slave_pkg::id_t sel_id;

    // ------------------------------------------------------------
    // Rotating-priority search
    // ------------------------------------------------------------
    // Walks upward from start_id; the 3-bit index wraps on its own
    always_comb begin
        axi_mem_slave_pkg::id_t idx;
        found  = 1'b0;
        sel_id = '0;
        idx    = start_id;
        for (int k = 0; k < axi_mem_slave_pkg::N_IDS; k++) begin
            if (!found && queue_valid[idx]) begin
                found  = 1'b1;
                sel_id = idx;
            end
            idx = idx + 1'b1;
        end
    end

    assign out_free = !rvalid || rready;

    // Head leaves its queue on the edge it is loaded
    assign pop    = out_free && found;
    assign pop_id = sel_id;

    // ------------------------------------------------------------
    // Response register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (out_free) begin
            rvalid <= found;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free && found) begin
            rdata <= queue_data[sel_id];
            rid   <= sel_id;
        end
    end

endmodule

`default_nettype wire

// File: src/axi_mem_slave.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_slave #(
    parameter int MEM_DEPTH  = 256,
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // Write address
    input  wire axi_mem_slave_pkg::addr_t   awaddr,
    input  wire logic                       awvalid,
    output logic                            awready,

    // Write data
    input  wire axi_mem_slave_pkg::data_t   wdata,
    input  wire logic                       wvalid,
    output logic                            wready,

    // Read address
    input  wire axi_mem_slave_pkg::addr_t   araddr,
    input  wire axi_mem_slave_pkg::id_t     arid,
    input  wire logic                       arvalid,
    output logic                            arready,

    // Read data
    output axi_mem_slave_pkg::data_t        rdata,
    output axi_mem_slave_pkg::id_t          rid,
    output logic                            rvalid,
    input  wire logic                       rready,

    // Write response
    output logic                            bvalid,
    input  wire logic                       bready
);

    localparam int MEM_AW = $clog2(MEM_DEPTH);

    logic aw_allow;
    logic w_allow;
    logic ar_allow;
    axi_mem_slave_pkg::id_t start_id;

    logic mem_we;
    logic [MEM_AW-1:0] mem_waddr;
    logic [MEM_AW-1:0] mem_raddr;
    axi_mem_slave_pkg::data_t mem_wdata;
    axi_mem_slave_pkg::data_t mem_rdata;

    logic [axi_mem_slave_pkg::N_IDS-1:0] queue_valid;
    axi_mem_slave_pkg::data_t [axi_mem_slave_pkg::N_IDS-1:0] queue_data;
    logic pop;
    axi_mem_slave_pkg::id_t pop_id;

    // ------------------------------------------------------------
    // Ready grants
    // ------------------------------------------------------------
    ready_lfsr u_ready_lfsr (
        .clk      (clk),
        .rst      (rst),
        .aw_allow (aw_allow),
        .w_allow  (w_allow),
        .ar_allow (ar_allow),
        .start_id (start_id)
    );

    // ------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------
    write_join #(
        .MEM_DEPTH  (MEM_DEPTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_write_join (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .aw_allow  (aw_allow),
        .w_allow   (w_allow),
        .bready    (bready),
        .awready   (awready),
        .wready    (wready),
        .bvalid    (bvalid),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata)
    );

    slave_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_slave_memory (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata)
    );

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    read_queues #(
        .MEM_DEPTH  (MEM_DEPTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_read_queues (
        .clk         (clk),
        .rst         (rst),
        .araddr      (araddr),
        .arid        (arid),
        .arvalid     (arvalid),
        .ar_allow    (ar_allow),
        .pop         (pop),
        .pop_id      (pop_id),
        .mem_rdata   (mem_rdata),
        .arready     (arready),
        .mem_raddr   (mem_raddr),
        .queue_valid (queue_valid),
        .queue_data  (queue_data)
    );

    read_arbiter u_read_arbiter (
        .clk         (clk),
        .rst         (rst),
        .queue_valid (queue_valid),
        .queue_data  (queue_data),
        .start_id    (start_id),
        .rready      (rready),
        .rdata       (rdata),
        .rid         (rid),
        .rvalid      (rvalid),
        .pop         (pop),
        .pop_id      (pop_id)
    );

endmodule

`default_nettype wire

// File: test/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

    // Reset releases just after a rising edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: test/axi_mem_slave_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_slave_assertions (
    input wire logic                     clk,
    input wire logic                     rst,
    input wire logic                     rvalid,
    input wire logic                     rready,
    input wire axi_mem_slave_pkg::data_t rdata,
    input wire axi_mem_slave_pkg::id_t   rid,
    input wire logic                     bvalid,
    input wire logic                     bready
);

    // Read beat holds under back-pressure
    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid))
        else $error("Read response changed while rready was low");

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // Registered outputs come out of a reset edge low
    reset_idle: assert property (@(posedge clk) rst |=> !rvalid && !bvalid)
        else $error("rvalid or bvalid high after a reset edge");

endmodule

bind axi_mem_slave axi_mem_slave_assertions u_assertions (
    .clk    (clk),
    .rst    (rst),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .rid    (rid),
    .bvalid (bvalid),
    .bready (bready)
);

`default_nettype wire

// File: test/axi_mem_slave_tb.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_slave_tb;

    localparam int MEM_DEPTH     = 256;
    localparam int FIFO_DEPTH    = 16;
    localparam int RESET_CYCLES  = 16;
    localparam int CYCLES_PER_OP = 60;

    logic clk;
    logic rst;
    axi_mem_slave_pkg::addr_t awaddr;
    logic awvalid;
    logic awready;
    axi_mem_slave_pkg::data_t wdata;
    logic wvalid;
    logic wready;
    axi_mem_slave_pkg::addr_t araddr;
    axi_mem_slave_pkg::id_t arid;
    logic arvalid;
    logic arready;
    axi_mem_slave_pkg::data_t rdata;
    axi_mem_slave_pkg::id_t rid;
    logic rvalid;
    logic rready;
    logic bvalid;
    logic bready;

    integer seed = 32'h05470638;
    int errors = 0;
    int reads_issued = 0;
    int resp_count = 0;
    int writes_issued = 0;
    int bresp_count = 0;
    logic trace_ready = 1'b0;

    // Parsed trace, one entry per operation
    byte op_q [$];
    logic [31:0] arg0_q [$];
    logic [31:0] arg1_q [$];
    logic [31:0] arg2_q [$];

    // Reference model: expected read data per ID, oldest first
    axi_mem_slave_pkg::data_t exp_q [axi_mem_slave_pkg::N_IDS][$];

    clock_gen #(
        .PERIOD       (20),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    axi_mem_slave #(
        .MEM_DEPTH  (MEM_DEPTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .araddr  (araddr),
        .arid    (arid),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rid     (rid),
        .rvalid  (rvalid),
        .rready  (rready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    // ------------------------------------------------------------
    // Trace loading
    // ------------------------------------------------------------
    task automatic load_trace(output bit ok);
        int fd;
        int code;
        logic [8*16-1:0] tok;
        logic [8*128-1:0] rest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        byte op;
        ok = 1'b0;
        fd = $fopen("test/axi_mem_slave_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", tok) == 1) begin
                op = tok[7:0];
                a = '0;
                b = '0;
                c = '0;
                code = 0;
                case (op)
                    "#": code = $fgets(rest, fd);
                    "W": code = $fscanf(fd, "%h %h", a, b);
                    "R": code = $fscanf(fd, "%h %h %h", a, b, c);
                    "B": code = 0;
                    default: begin
                        $display("Trace holds an unknown operation");
                        ok = 1'b0;
                    end
                endcase
                if ((op == "W" && code != 2) || (op == "R" && code != 3)) begin
                    $display("Trace line for operation %s is incomplete", op);
                    ok = 1'b0;
                end
                if (op == "W" || op == "R" || op == "B") begin
                    op_q.push_back(op);
                    arg0_q.push_back(a);
                    arg1_q.push_back(b);
                    arg2_q.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus, all changes 1 ns after the rising edge
    // ------------------------------------------------------------
    task automatic send_addr(input axi_mem_slave_pkg::addr_t addr, input int delay);
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        awaddr  = addr;
        awvalid = 1'b1;
        do begin
            @(negedge clk);
        end while (!awready);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
    endtask

    task automatic send_data(input axi_mem_slave_pkg::data_t data, input int delay);
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        wdata  = data;
        wvalid = 1'b1;
        do begin
            @(negedge clk);
        end while (!wready);
        @(posedge clk);
        #1;
        wvalid = 1'b0;
    endtask

    task automatic do_write(input axi_mem_slave_pkg::addr_t addr,
                            input axi_mem_slave_pkg::data_t data);
        int addr_delay;
        int data_delay;
        addr_delay = $random(seed) & 3;
        data_delay = $random(seed) & 3;
        fork
            send_addr(addr, addr_delay);
            send_data(data, data_delay);
        join
        writes_issued++;
    endtask

    task automatic do_read(input axi_mem_slave_pkg::id_t id,
                           input axi_mem_slave_pkg::addr_t addr,
                           input axi_mem_slave_pkg::data_t expected);
        arid    = id;
        araddr  = addr;
        arvalid = 1'b1;
        do begin
            @(negedge clk);
        end while (!arready);
        exp_q[id].push_back(expected);
        reads_issued++;
        @(posedge clk);
        #1;
        arvalid = 1'b0;
    endtask

    // Everything answered, then a few idle cycles to catch extra beats
    task automatic wait_barrier();
        wait (resp_count >= reads_issued && bresp_count >= writes_issued);
        repeat (4) @(posedge clk);
        #1;
        assert (resp_count == reads_issued) else begin
            $display("Mismatch read responses: got %h expected %h", resp_count, reads_issued);
            errors++;
        end
        assert (bresp_count == writes_issued) else begin
            $display("Mismatch bvalid handshakes: got %h expected %h",
                     bresp_count, writes_issued);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic check_idle();
        assert (rvalid == 1'b0) else begin
            $display("Mismatch rvalid: got %h expected %h", rvalid, 1'b0);
            errors++;
        end
        assert (bvalid == 1'b0) else begin
            $display("Mismatch bvalid: got %h expected %h", bvalid, 1'b0);
            errors++;
        end
    endtask

    task automatic check_response();
        axi_mem_slave_pkg::data_t expected;
        resp_count++;
        assert (exp_q[rid].size() > 0) else begin
            $display("Read response with rid %0d came with no read outstanding for it", rid);
            errors++;
        end
        if (exp_q[rid].size() > 0) begin
            expected = exp_q[rid].pop_front();
            assert (rdata == expected) else begin
                $display("Mismatch rdata (rid %h): got %h expected %h", rid, rdata, expected);
                errors++;
            end
        end
    endtask

    // Mid-cycle sample: a high valid/ready pair here transfers at the next edge
    always @(negedge clk) begin
        if (!rst && rvalid && rready) begin
            check_response();
        end
        if (!rst && bvalid && bready) begin
            bresp_count++;
        end
    end

    // Random back-pressure, about 75 % rready and 50 % bready
    always @(posedge clk) begin
        #1;
        rready = ($random(seed) & 3) != 0;
        bready = ($random(seed) & 1) != 0;
    end

    initial begin
        wait (trace_ready);
        repeat (RESET_CYCLES + CYCLES_PER_OP * op_q.size()) @(posedge clk);
        $display("Timeout: responses still missing when the watchdog expired");
        $display("Reads %0d, responses %0d, writes %0d, write responses %0d, errors %0d",
                 reads_issued, resp_count, writes_issued, bresp_count, errors);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        bit loaded;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        araddr  = '0;
        arid    = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        bready  = 1'b0;
        load_trace(loaded);
        if (!loaded) begin
            $display("Trace file is missing or malformed");
            $display("Simulation failed");
            $finish;
        end else begin
            trace_ready = 1'b1;
            @(posedge clk);
            while (rst) begin
                @(negedge clk);
                check_idle();
            end
            @(negedge clk);
            check_idle();
            @(posedge clk);
            #1;
            for (int i = 0; i < op_q.size(); i++) begin
                case (op_q[i])
                    "W": do_write(arg0_q[i], arg1_q[i]);
                    "R": do_read(axi_mem_slave_pkg::id_t'(arg0_q[i]), arg1_q[i], arg2_q[i]);
                    default: wait_barrier();
                endcase
            end
            wait_barrier();
            $display("Reads %0d, responses %0d, writes %0d, write responses %0d, errors %0d",
                     reads_issued, resp_count, writes_issued, bresp_count, errors);
            if (errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: test/axi_mem_slave_trace.txt
# W addr data | R id addr expected | B waits for all read and write responses
# All values in hex; the memory index is the low 8 address bits
R 0 00000010 00000000
R 3 000000ff 00000000
R 6 00000040 00000000
B
W 00000004 11110004
W 00000008 22220008
W 0000000c 3333000c
W 00000004 aaaa0004
W 00000020 44440020
W 000000f0 5555f0f0
B
R 0 00000004 aaaa0004
R 1 00000008 22220008
R 2 0000000c 3333000c
R 0 00000008 22220008
R 5 00000020 44440020
R 1 000000f0 5555f0f0
R 7 00000010 00000000
R 2 00000004 aaaa0004
R 0 000000f0 5555f0f0
R 5 0000000c 3333000c
B
W 00000008 66660008
W 00000010 77770010
W 00000020 88880020
B
R 4 00000008 66660008
R 4 00000010 77770010
R 3 00000020 88880020
R 4 00000004 aaaa0004
R 6 000000f0 5555f0f0
B

// File: axi_mem_slave.f
src/axi_mem_slave_pkg.sv
src/sync_fifo.sv
src/ready_lfsr.sv
src/write_join.sv
src/slave_memory.sv
src/read_queues.sv
src/read_arbiter.sv
src/axi_mem_slave.sv
test/clock_gen.sv
test/axi_mem_slave_assertions.sv
test/axi_mem_slave_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module axi_mem_slave_tb \
    -f axi_mem_slave.f -o axi_mem_slave_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/axi_mem_slave_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0
